//--- rtl/degu_soc_pkg.sv
`default_nettype none

package degu_soc_pkg;

//////////////////////////////////////////////////
// widths and address map
//////////////////////////////////////////////////

  // data and address width
  localparam int unsigned XLEN = 32;
  // byte lanes per word
  localparam int unsigned BLEN = XLEN/8;
  // peripheral (1) or data memory (0)
  localparam int unsigned REGION_BIT = 14;
  // inside peripherals: UART window (1) or GPIO (0)
  localparam int unsigned PER_SEL_BIT = 6;

//////////////////////////////////////////////////
// address word, two decodings
//////////////////////////////////////////////////

  typedef union packed {
    // data memory view
    struct packed {
      logic [XLEN-2-REGION_BIT:0]           upper;
      logic                                 region;
      logic [REGION_BIT-3:0]                word;
      logic [$clog2(BLEN)-1:0]              boff;
    } mem;
    // peripheral view
    struct packed {
      logic [XLEN-2-REGION_BIT:0]           upper;
      logic                                 region;
      logic [REGION_BIT-PER_SEL_BIT-2:0]    unused;
      logic                                 per_sel;
      logic [PER_SEL_BIT-3:0]               regidx;
      logic [$clog2(BLEN)-1:0]              boff;
    } per;
  } soc_addr_u;

//////////////////////////////////////////////////
// APB request and response
//////////////////////////////////////////////////

  typedef struct packed {
    logic            psel;
    logic            penable;
    logic            pwrite;
    soc_addr_u       paddr;
    logic [BLEN-1:0] pstrb;
    logic [XLEN-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;
  } apb_rsp_t;

  // GPIO register indices, others undefined
  typedef enum logic [PER_SEL_BIT-3:0] {
    GPIO_OUT = 4'd0,
    GPIO_ENA = 4'd1,
    GPIO_INP = 4'd2
  } gpio_reg_e;

endpackage: degu_soc_pkg

`default_nettype wire

//--- rtl/degu_apb_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module degu_apb_decoder
  import degu_soc_pkg::*;
(
  // upstream port from the master
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  // data memory port
  output apb_req_t mem_req,
  input  apb_rsp_t mem_rsp,
  // GPIO port
  output apb_req_t gpio_req,
  input  apb_rsp_t gpio_rsp
);

//////////////////////////////////////////////////
// address decoding
//////////////////////////////////////////////////

  // nothing mapped above the region bit
  logic addr_ok;
  // one-hot target select
  logic sel_mem;
  logic sel_gpio;
  logic sel_err;

  // upper field is the same in both views
  assign addr_ok = (apb_req.paddr.mem.upper == '0);

  // region 0: data memory, word view
  assign sel_mem = addr_ok & ~apb_req.paddr.mem.region;

  // region 1: peripheral view
  // lower half is GPIO
  assign sel_gpio = addr_ok
                  & apb_req.paddr.per.region
                  & ~apb_req.paddr.per.per_sel;

  // UART window and out-of-range addresses
  assign sel_err = ~sel_mem & ~sel_gpio;

//////////////////////////////////////////////////
// request routing
//////////////////////////////////////////////////

  // same request to all targets
  // only the selected one sees psel
  always_comb begin
    mem_req      = apb_req;
    mem_req.psel = apb_req.psel & sel_mem;
  end

  always_comb begin
    gpio_req      = apb_req;
    gpio_req.psel = apb_req.psel & sel_gpio;
  end

//////////////////////////////////////////////////
// response multiplexer
//////////////////////////////////////////////////

  always_comb begin
    if (sel_err) begin
      // error answered here in the first access cycle
      apb_rsp.prdata  = '0;
      apb_rsp.pready  = 1'b1;
      apb_rsp.pslverr = 1'b1;
    end else if (sel_gpio) begin
      apb_rsp = gpio_rsp;
    end else begin
      // data memory, pready from its wait state
      apb_rsp = mem_rsp;
    end
  end

endmodule: degu_apb_decoder

`default_nettype wire

//--- rtl/degu_data_memory.sv
`timescale 1ns/10ps
`default_nettype none

module degu_data_memory
  import degu_soc_pkg::*;
#(
  // depth in words, aliases inside the 4096 word window
  parameter int unsigned MEM_WORDS = 4096
)(
  // system signals
  input  logic     clk,
  input  logic     rst,
  // APB target port
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  // array address width
  localparam int unsigned AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

//////////////////////////////////////////////////
// local signals
//////////////////////////////////////////////////

  // word storage
  logic [XLEN-1:0] mem [MEM_WORDS];
  // word index after wrap
  logic [AW-1:0]   addr;
  // first access cycle
  logic            access;
  // wait state flag, high in the second access cycle
  logic            wait_q;
  // registered read word
  logic [XLEN-1:0] rdata_q;

  // modulo keeps smaller memories aliased
  assign addr = AW'(apb_req.paddr.mem.word % MEM_WORDS);

  // not yet in the wait state
  assign access = apb_req.psel & apb_req.penable & ~wait_q;

//////////////////////////////////////////////////
// wait state
//////////////////////////////////////////////////

  // set after the first access cycle, cleared after the second
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access;
    end
  end

//////////////////////////////////////////////////
// array access
//////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (access) begin
      if (apb_req.pwrite) begin
        // enabled byte lanes only
        for (int b = 0; b < BLEN; b++) begin
          if (apb_req.pstrb[b]) begin
            mem[addr][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[addr];
      end
    end
  end

  // response, data valid with pready
  assign apb_rsp.prdata  = rdata_q;
  assign apb_rsp.pready  = wait_q;
  assign apb_rsp.pslverr = 1'b0;

endmodule: degu_data_memory

`default_nettype wire

//--- rtl/degu_gpio.sv
`timescale 1ns/10ps
`default_nettype none

module degu_gpio
  import degu_soc_pkg::*;
#(
  // GPIO width, up to XLEN
  parameter int unsigned GW = 32
)(
  // system signals
  input  logic          clk,
  input  logic          rst,
  // APB target port
  input  apb_req_t      apb_req,
  output apb_rsp_t      apb_rsp,
  // GPIO pads
  output logic [GW-1:0] gpio_drive,
  output logic [GW-1:0] gpio_enable,
  input  logic [GW-1:0] gpio_pins
);

//////////////////////////////////////////////////
// local signals
//////////////////////////////////////////////////

  // register index from the peripheral view
  gpio_reg_e       reg_idx;
  // write in the access cycle
  logic            wr_en;
  // per-bit mask from pstrb
  logic [XLEN-1:0] strb_mask;
  // read mux output
  logic [XLEN-1:0] rd_data;
  // undefined register index
  logic            reg_err;
  // input synchronizer stages
  logic [GW-1:0]   sync_q1;
  logic [GW-1:0]   sync_q2;

  assign reg_idx = gpio_reg_e'(apb_req.paddr.per.regidx);
  assign wr_en   = apb_req.psel & apb_req.penable & apb_req.pwrite;

  // expand byte strobes to bits
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      strb_mask[i] = apb_req.pstrb[i/8];
    end
  end

//////////////////////////////////////////////////
// output and enable registers
//////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_drive  <= '0;
      gpio_enable <= '0;
    end else if (wr_en) begin
      // input register and undefined indices ignore writes
      case (reg_idx)
        GPIO_OUT: gpio_drive  <= (gpio_drive & ~strb_mask[GW-1:0])
                               | (apb_req.pwdata[GW-1:0] & strb_mask[GW-1:0]);
        GPIO_ENA: gpio_enable <= (gpio_enable & ~strb_mask[GW-1:0])
                               | (apb_req.pwdata[GW-1:0] & strb_mask[GW-1:0]);
        default: ;
      endcase
    end
  end

//////////////////////////////////////////////////
// input synchronizer
//////////////////////////////////////////////////

  // two flops, pin level visible after two edges
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_pins;
      sync_q2 <= sync_q1;
    end
  end

//////////////////////////////////////////////////
// read and response
//////////////////////////////////////////////////

  // zero extended to XLEN
  always_comb begin
    rd_data = '0;
    reg_err = 1'b0;
    case (reg_idx)
      GPIO_OUT: rd_data = XLEN'(gpio_drive);
      GPIO_ENA: rd_data = XLEN'(gpio_enable);
      GPIO_INP: rd_data = XLEN'(sync_q2);
      default:  reg_err = 1'b1;
    endcase
  end

  // answers in the first access cycle
  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = reg_err;

endmodule: degu_gpio

`default_nettype wire

//--- rtl/degu_soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module degu_soc_top
  import degu_soc_pkg::*;
#(
  // data memory depth in words, at most 4096
  parameter int unsigned MEM_WORDS = 4096,
  // GPIO width
  parameter int unsigned GW = 32
)(
  // system signals
  input  logic          clk,
  input  logic          rst,
  // APB port from the external master
  input  apb_req_t      apb_req,
  output apb_rsp_t      apb_rsp,
  // GPIO pads
  output logic [GW-1:0] gpio_drive,
  output logic [GW-1:0] gpio_enable,
  input  logic [GW-1:0] gpio_pins
);

//////////////////////////////////////////////////
// local busses
//////////////////////////////////////////////////

  // data memory branch
  apb_req_t mem_req;
  apb_rsp_t mem_rsp;
  // GPIO branch
  apb_req_t gpio_req;
  apb_rsp_t gpio_rsp;

//////////////////////////////////////////////////
// address decoder
//////////////////////////////////////////////////

  // memory / GPIO / error split
  degu_apb_decoder decoder (
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp)
  );

//////////////////////////////////////////////////
// targets
//////////////////////////////////////////////////

  // data memory, one wait state
  degu_data_memory #(
    .MEM_WORDS (MEM_WORDS)
  ) dmem (
    .clk     (clk),
    .rst     (rst),
    .apb_req (mem_req),
    .apb_rsp (mem_rsp)
  );

  // GPIO controller, zero wait states
  degu_gpio #(
    .GW (GW)
  ) gpio (
    .clk         (clk),
    .rst         (rst),
    .apb_req     (gpio_req),
    .apb_rsp     (gpio_rsp),
    .gpio_drive  (gpio_drive),
    .gpio_enable (gpio_enable),
    .gpio_pins   (gpio_pins)
  );

endmodule: degu_soc_top

`default_nettype wire

//--- verif/degu_soc_tb_tasks.svh
//////////////////////////////////////////////////
// APB master
//////////////////////////////////////////////////

// setup cycle, then access cycles until pready
task automatic run_transfer(input  logic            write,
                            input  logic [XLEN-1:0] addr,
                            input  logic [BLEN-1:0] strb,
                            input  logic [XLEN-1:0] wdata,
                            output logic [XLEN-1:0] rdata,
                            output logic            err,
                            output logic            ok);
  apb_req_t    req;
  int unsigned waited;
  int unsigned exp_wait;
  req        = '0;
  req.psel   = 1'b1;
  req.pwrite = write;
  req.paddr  = addr;
  req.pstrb  = strb;
  req.pwdata = wdata;
  rdata  = '0;
  err    = 1'b0;
  ok     = 1'b0;
  waited = 0;
  // one wait state for data memory only
  exp_wait = (addr[XLEN-1:14] == '0) ? 1 : 0;
  @(posedge clk);
  apb_req <= req;
  req.penable = 1'b1;
  @(posedge clk);
  apb_req <= req;
  // sample mid cycle while the request is held
  @(negedge clk);
  while (!apb_rsp.pready && waited < 20) begin
    waited++;
    @(negedge clk);
  end
  if (apb_rsp.pready) begin
    ok    = 1'b1;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_value($sformatf("pready wait @%h", addr), XLEN'(waited), XLEN'(exp_wait));
  end else begin
    fail_count++;
    $display("timeout: no pready within 20 cycles at address %h", addr);
  end
  // transfer completes on this edge
  @(posedge clk);
  apb_req <= '0;
endtask

// write with pslverr checked before the model follows
task automatic apb_write(input logic [XLEN-1:0] addr,
                         input logic [BLEN-1:0] strb,
                         input logic [XLEN-1:0] wdata);
  logic [XLEN-1:0] rdata;
  logic            err;
  logic            ok;
  logic [XLEN:0]   exp;
  exp = expected_read(addr);
  run_transfer(1'b1, addr, strb, wdata, rdata, err, ok);
  if (ok) begin
    check_value($sformatf("pslverr wr @%h", addr), XLEN'(err), XLEN'(exp[XLEN]));
    model_write(addr, strb, wdata);
  end
endtask

// read handed on to the compare process
task automatic apb_read(input logic [XLEN-1:0] addr);
  logic [XLEN-1:0] rdata;
  logic            err;
  logic            ok;
  run_transfer(1'b0, addr, '0, '0, rdata, err, ok);
  if (ok) begin
    rd_addr = addr;
    rd_data = rdata;
    rd_err  = err;
    -> read_done;
  end
endtask

task automatic check_value(input string           name,
                           input logic [XLEN-1:0] actual,
                           input logic [XLEN-1:0] expected);
  check_count++;
  if (actual !== expected) begin
    fail_count++;
    $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
  end
endtask

//--- verif/degu_soc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module degu_soc_tb
  import degu_soc_pkg::*;
#(
  // below 4096 so word indices alias
  parameter int unsigned MEM_WORDS = 1024
);

  localparam int unsigned GW = 32;
  localparam int unsigned AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

//////////////////////////////////////////////////
// DUT and its signals
//////////////////////////////////////////////////

  logic          clk;
  logic          rst;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  logic [GW-1:0] gpio_drive;
  logic [GW-1:0] gpio_enable;
  logic [GW-1:0] gpio_pins;

  degu_soc_top #(
    .MEM_WORDS (MEM_WORDS),
    .GW        (GW)
  ) DUT (
    .clk         (clk),
    .rst         (rst),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .gpio_drive  (gpio_drive),
    .gpio_enable (gpio_enable),
    .gpio_pins   (gpio_pins)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////

  logic [XLEN-1:0] model_mem [MEM_WORDS];
  logic [XLEN-1:0] model_drive;
  logic [XLEN-1:0] model_enable;
  logic [XLEN-1:0] model_pins;
  // last completed read for the compare process
  logic [XLEN-1:0] rd_addr;
  logic [XLEN-1:0] rd_data;
  logic            rd_err;
  event            read_done;
  // check counters
  int unsigned     check_count;
  int unsigned     fail_count;
  int unsigned     test_start;

  // address builders
  function automatic logic [XLEN-1:0] mem_addr(input int unsigned word);
    return {17'b0, 1'b0, 12'(word), 2'b00};
  endfunction

  function automatic logic [XLEN-1:0] gpio_addr(input int unsigned idx);
    return {17'b0, 1'b1, 7'b0, 1'b0, 4'(idx), 2'b00};
  endfunction

  function automatic logic [XLEN-1:0] uart_addr(input int unsigned idx);
    return {17'b0, 1'b1, 7'b0, 1'b1, 4'(idx), 2'b00};
  endfunction

  // byte strobes to bit mask
  function automatic logic [XLEN-1:0] lane_mask(input logic [BLEN-1:0] strb);
    logic [XLEN-1:0] mask;
    for (int b = 0; b < BLEN; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  // {pslverr, prdata} expected from the address map
  function automatic logic [XLEN:0] expected_read(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] data;
    logic            err;
    data = '0;
    err  = 1'b0;
    if (addr[XLEN-1:15] != '0) begin
      // nothing mapped above bit 14
      err = 1'b1;
    end else if (!addr[14]) begin
      data = model_mem[AW'(32'(addr[13:2]) % MEM_WORDS)];
    end else if (addr[6]) begin
      // UART window always errors
      err = 1'b1;
    end else begin
      case (addr[5:2])
        4'd0:    data = model_drive;
        4'd1:    data = model_enable;
        4'd2:    data = model_pins;
        default: err = 1'b1;
      endcase
    end
    return {err, data};
  endfunction

  // error targets and the input register keep their state
  function automatic void model_write(input logic [XLEN-1:0] addr,
                                      input logic [BLEN-1:0] strb,
                                      input logic [XLEN-1:0] wdata);
    logic [XLEN:0]   probe;
    logic [XLEN-1:0] mask;
    logic [AW-1:0]   idx;
    probe = expected_read(addr);
    mask  = lane_mask(strb);
    idx   = AW'(32'(addr[13:2]) % MEM_WORDS);
    if (!probe[XLEN]) begin
      if (!addr[14]) begin
        model_mem[idx] = (model_mem[idx] & ~mask) | (wdata & mask);
      end else if (addr[5:2] == 4'd0) begin
        model_drive = (model_drive & ~mask) | (wdata & mask);
      end else if (addr[5:2] == 4'd1) begin
        model_enable = (model_enable & ~mask) | (wdata & mask);
      end
    end
  endfunction

  // compare every completed read
  always @(read_done) begin
    logic [XLEN:0] exp;
    exp = expected_read(rd_addr);
    check_value($sformatf("prdata @%h", rd_addr), rd_data, exp[XLEN-1:0]);
    check_value($sformatf("pslverr @%h", rd_addr), XLEN'(rd_err), XLEN'(exp[XLEN]));
  end

  task automatic report_test(input string name);
    // compare process done with the last read
    @(negedge clk);
    $display("test %-12s done, %0d errors", name, fail_count - test_start);
    test_start = fail_count;
  endtask

//////////////////////////////////////////////////
// test sequence
//////////////////////////////////////////////////

  initial begin
    int unsigned     words [64];
    int unsigned     w;
    logic [XLEN-1:0] data;
    logic [BLEN-1:0] strb;
    void'($urandom(32'h9c5d));
    check_count  = 0;
    fail_count   = 0;
    test_start   = 0;
    model_drive  = '0;
    model_enable = '0;
    model_pins   = '0;
    rst       <= 1'b1;
    apb_req   <= '0;
    gpio_pins <= '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // reset values
    check_value("gpio_drive", gpio_drive, '0);
    check_value("gpio_enable", gpio_enable, '0);
    apb_read(gpio_addr(0));
    apb_read(gpio_addr(1));
    report_test("reset");

    // full words and aliased reads
    for (int i = 0; i < 64; i++) begin
      words[i] = $urandom_range(4095);
      apb_write(mem_addr(words[i]), 4'hf, $urandom);
    end
    for (int i = 0; i < 64; i++) begin
      apb_read(mem_addr(words[i]));
      apb_read(mem_addr((words[i] + MEM_WORDS) % 4096));
    end
    report_test("memory");

    // partial strobes over a known word
    for (int i = 0; i < 32; i++) begin
      w    = $urandom_range(4095);
      strb = 4'($urandom);
      apb_write(mem_addr(w), 4'hf, $urandom);
      apb_write(mem_addr(w), strb, $urandom);
      apb_read(mem_addr(w));
    end
    report_test("strobes");

    // output and enable registers
    for (int i = 0; i < 32; i++) begin
      strb = (i % 3 == 0) ? 4'($urandom) : 4'hf;
      w    = $urandom_range(1);
      apb_write(gpio_addr(w), strb, $urandom);
      @(negedge clk);
      check_value("gpio_drive", gpio_drive, model_drive);
      check_value("gpio_enable", gpio_enable, model_enable);
      apb_read(gpio_addr(w));
    end
    report_test("gpio_out");

    // pins through the synchronizer into the read-only input register
    for (int i = 0; i < 8; i++) begin
      data = $urandom;
      @(posedge clk);
      gpio_pins  <= data;
      model_pins  = data;
      repeat (3) @(posedge clk);
      apb_read(gpio_addr(2));
      apb_write(gpio_addr(2), 4'hf, ~data);
      apb_read(gpio_addr(2));
    end
    report_test("gpio_in");

    // UART window, undefined indices, upper bits
    for (int i = 0; i < 8; i++) begin
      w = $urandom_range(15);
      apb_write(uart_addr(w), 4'hf, $urandom);
      apb_read(uart_addr(w));
    end
    for (int i = 3; i < 16; i++) begin
      apb_write(gpio_addr(i), 4'hf, $urandom);
      apb_read(gpio_addr(i));
    end
    for (int i = 0; i < 8; i++) begin
      data = (32'h1 << (15 + $urandom_range(16))) | mem_addr(words[i]);
      apb_write(data, 4'hf, $urandom);
      apb_read(data);
      // aliased word must be untouched
      apb_read(mem_addr(words[i]));
    end
    apb_read(gpio_addr(0));
    apb_read(gpio_addr(1));
    @(negedge clk);
    check_value("gpio_drive", gpio_drive, model_drive);
    check_value("gpio_enable", gpio_enable, model_enable);
    report_test("errors");

    $display("checks %0d, errors %0d", check_count, fail_count);
    if (fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

`include "degu_soc_tb_tasks.svh"

endmodule: degu_soc_tb

`default_nettype wire

//--- filelist.f
rtl/degu_soc_pkg.sv
rtl/degu_apb_decoder.sv
rtl/degu_data_memory.sv
rtl/degu_gpio.sv
rtl/degu_soc_top.sv
+incdir+verif
verif/degu_soc_tb.sv

//--- Makefile
# Verilator build and run for the degu SoC testbench

VERILATOR  ?= verilator
TOP        ?= degu_soc_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
MEM_WORDS  ?= 1024
VFLAGS     ?= --timescale 1ns/10ps
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= Regression passed

# sources from the file list, plus the included headers
SRCS    := $(filter-out +incdir%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verif/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) --binary --timing $(VFLAGS) \
	  -f $(FILELIST) \
	  --top-module $(TOP) \
	  -GMEM_WORDS=$(MEM_WORDS) \
	  --Mdir $(BUILD_DIR) \
	  -o V$(TOP)

# the log decides pass or fail
run: build
	./$(BINARY) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) $(VFLAGS) \
	  -f $(FILELIST) \
	  --top-module $(TOP) \
	  -GMEM_WORDS=$(MEM_WORDS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
